//--- include/pram_defaults.svh
`ifndef PRAM_DEFAULTS_SVH
`define PRAM_DEFAULTS_SVH

img[0]  = 128'h00000001_00000d06_02010100_01000000;
img[1]  = 128'h00000706_02010100_00000f05_01000506;
img[2]  = 128'h01000000_00010101_07000000_03020202;
img[3]  = 128'h00000000_00000000_00000102_03040506;
img[4]  = 128'h07000001_02030405_06070809_0a0b0c0d;
img[5]  = 128'h0e0fffff_ffffffff_ff00ffff_ffffff81;
img[6]  = 128'hffffffff_ffffffff_ffffffff_ffffffff;
img[7]  = 128'hffffffff_ffffffff_ffffffff_ffffffff;
img[8]  = 128'hffffffff_ffffffff_ffffffff_ffffffff;
img[9]  = 128'hffffffff_ffffffff_ffffffff_ffffffff;
img[10] = 128'hffffffff_ffffffff_ffffffff_ffffffff;
img[11] = 128'hffffffff_ffffffff_ffffffff_ffffffff;
img[12] = 128'hffffffff_ffffffff_ffffffff_ffffffff;
img[13] = 128'hffffffff_ffffffff_ffffffff_ffffffff;
img[14] = 128'hffffffff_ffffffff_ffffffff_ffffffff;
img[15] = 128'hffffffff_ffffffff_ffffffff_7153dbf9;

`endif

//--- logic/rtc_pkg.sv
package rtc_pkg;

  // seconds between the mac epoch and the unix epoch
  localparam logic [31:0] mac_epoch_offset = 32'd2082844800;

  typedef enum logic [2:0] {
    st_idle,
    st_addr2,     // waiting for second byte of extended address
    st_pram,
    st_clock,
    st_internal
  } rtc_state_e;

  typedef enum logic [2:0] {
    cmd_none,
    cmd_clock,
    cmd_internal,
    cmd_pram_hi,  // 100ab short form
    cmd_pram_lo,  // 0abcd short form
    cmd_pram_ext
  } rtc_cmd_e;

  typedef struct packed {
    logic       addr;    // 0 = c033, 1 = c034
    logic       rw;      // 1 = read
    logic       strobe;
    logic       cen;
    logic [7:0] din;
  } rtc_bus_t;

  typedef struct packed {
    logic       en;
    logic       we;
    logic [7:0] addr;
    logic [7:0] wdata;
  } rtc_mem_req_t;

  // first match wins
  function automatic rtc_cmd_e decode_cmd(input logic [7:0] cmd);
    rtc_cmd_e cls;
    casez (cmd)
      8'b?000??01: cls = cmd_clock;
      8'b00110?01: cls = cmd_internal;
      8'b?010??01: cls = cmd_pram_hi;
      8'b?1????01: cls = cmd_pram_lo;
      8'b?0111???: cls = cmd_pram_ext;
      default:     cls = cmd_none;
    endcase
    return cls;
  endfunction

endpackage

//--- logic/rtc_pram.sv
`timescale 1ns/1ns

module rtc_pram import rtc_pkg::*; (
  input  logic         CLK_14M,
  input  rtc_mem_req_t req,
  output logic [7:0]   rdata
);

  logic [7:0]   mem [256];

  // row n holds bytes 16n to 16n+15 with the lowest address leftmost
  logic [127:0] img [16];

  initial begin
    `include "pram_defaults.svh"
    for (int i = 0; i < 256; i++) begin
      mem[i] = img[i / 16][8 * (15 - (i % 16)) +: 8];
    end
  end

  always_ff @(posedge CLK_14M) begin
    if (req.en) begin
      if (req.we) begin
        mem[req.addr] <= req.wdata;
      end
      rdata <= mem[req.addr];  // old contents on a write
    end
  end

endmodule

//--- logic/rtc_seconds.sv
`timescale 1ns/1ns

module rtc_seconds import rtc_pkg::*; #(
  parameter int ticks_per_sec = 14318181
) (
  input  logic         CLK_14M,
  input  logic         rst_n,
  input  logic [32:0]  timestamp,
  input  rtc_mem_req_t req,
  output logic [7:0]   rdata,
  output logic         onesecond_irq,
  output logic         qtrsecond_irq
);

  localparam int qtr_ticks = ticks_per_sec / 4;
  localparam int cnt_w     = $clog2(ticks_per_sec);

  logic [cnt_w-1:0] sec_cnt;
  logic [cnt_w-1:0] qtr_cnt;
  logic [31:0]      seconds;  // little endian over clock bytes 0..3
  logic             sec_wrap;
  logic             qtr_wrap;

  assign sec_wrap = (sec_cnt == cnt_w'(ticks_per_sec - 1));
  assign qtr_wrap = (qtr_cnt == cnt_w'(qtr_ticks - 1));

  assign onesecond_irq = sec_wrap;
  assign qtrsecond_irq = qtr_wrap;

  // prescalers run on every clock regardless of cen
  always_ff @(posedge CLK_14M or negedge rst_n) begin
    if (!rst_n) begin
      sec_cnt <= '0;
      qtr_cnt <= '0;
    end else begin
      sec_cnt <= sec_wrap ? '0 : sec_cnt + 1'b1;
      qtr_cnt <= qtr_wrap ? '0 : qtr_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK_14M or negedge rst_n) begin
    if (!rst_n) begin
      seconds <= '0;
    end else if (req.en && req.we) begin
      seconds[{req.addr[1:0], 3'b000} +: 8] <= req.wdata;  // host wins over tick
    end else if (seconds == '0) begin
      seconds <= timestamp[31:0] + mac_epoch_offset;  // unix time to mac time
    end else if (sec_wrap) begin
      seconds <= seconds + 32'd1;
    end
  end

  always_ff @(posedge CLK_14M) begin
    if (req.en) begin
      rdata <= seconds[{req.addr[1:0], 3'b000} +: 8];
    end
  end

endmodule

//--- logic/rtc_cmd_seq.sv
`timescale 1ns/1ns

module rtc_cmd_seq import rtc_pkg::*; (
  input  logic         CLK_14M,
  input  logic         rst_n,
  input  rtc_bus_t     bus,
  output logic [7:0]   dout,
  output rtc_mem_req_t pram_req,
  output rtc_mem_req_t clk_req,
  input  logic [7:0]   pram_rdata,
  input  logic [7:0]   clk_rdata
);

  logic [7:0] c033;      // data register
  logic [6:0] c034;      // control register bits 6:0
  rtc_state_e state;
  logic [7:0] tgt_addr;  // latched target address
  logic       rd_pend;
  logic       rd_pram;   // pending read from parameter RAM

  logic       access;
  logic       ctl_step;
  logic       data_step;
  logic       step_rd;
  rtc_cmd_e   cmd;

  assign access    = bus.strobe && bus.cen;
  assign ctl_step  = access && !bus.rw && bus.addr && bus.din[7];
  assign data_step = ctl_step && (state == st_pram || state == st_clock);
  assign step_rd   = bus.din[6];  // direction of this data step
  assign cmd       = decode_cmd(c033);

  // requests live only in the strobe cycle of the data step
  always_comb begin
    pram_req.en    = ctl_step && (state == st_pram);
    pram_req.we    = !step_rd;
    pram_req.addr  = tgt_addr;
    pram_req.wdata = c033;

    clk_req.en     = ctl_step && (state == st_clock);
    clk_req.we     = !step_rd;
    clk_req.addr   = tgt_addr;
    clk_req.wdata  = c033;
  end

  // host registers and read-back
  always_ff @(posedge CLK_14M or negedge rst_n) begin
    if (!rst_n) begin
      c033 <= '0;
      c034 <= '0;
      dout <= '0;
    end else begin
      if (rd_pend) begin
        c033 <= rd_pram ? pram_rdata : clk_rdata;  // target data one cycle late
      end
      if (access) begin
        if (bus.rw) begin
          dout <= bus.addr ? {1'b0, c034} : c033;
        end else if (bus.addr) begin
          c034 <= bus.din[6:0];
        end else begin
          c033 <= bus.din;
        end
      end
    end
  end

  // command sequencer advanced by control writes with bit 7 set
  always_ff @(posedge CLK_14M or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      tgt_addr <= '0;
      rd_pend  <= 1'b0;
      rd_pram  <= 1'b0;
    end else begin
      rd_pend <= data_step && step_rd;
      if (data_step) begin
        rd_pram <= (state == st_pram);
      end

      if (ctl_step) begin
        case (state)
          st_idle: begin
            case (cmd)
              cmd_clock: begin
                tgt_addr <= {6'd0, c033[3:2]};  // clock byte ab
                state    <= st_clock;
              end
              cmd_internal: begin
                tgt_addr <= {7'd0, c033[2]};  // test or write protect
                state    <= st_internal;
              end
              cmd_pram_hi: begin
                tgt_addr <= {6'b000100, c033[3:2]};
                state    <= st_pram;
              end
              cmd_pram_lo: begin
                tgt_addr <= {4'd0, c033[5:2]};
                state    <= st_pram;
              end
              cmd_pram_ext: begin
                tgt_addr[7:5] <= c033[2:0];
                state         <= st_addr2;
              end
              default: begin
                state <= st_idle;  // unknown command ignored
              end
            endcase
          end

          st_addr2: begin
            tgt_addr[4:0] <= c033[6:2];  // low bits from second byte
            state         <= st_pram;
          end

          // data step issues its request combinationally
          st_pram: begin
            state <= st_idle;
          end

          st_clock: begin
            state <= st_idle;
          end

          // internal registers complete with no effect
          st_internal: begin
            state <= st_idle;
          end

          default: begin
            state <= st_idle;
          end
        endcase
      end
    end
  end

endmodule

//--- logic/rtc_top.sv
`timescale 1ns/1ns

module rtc_top import rtc_pkg::*; #(
  parameter int ticks_per_sec = 14318181
) (
  input  logic        CLK_14M,
  input  logic        rst_n,
  input  rtc_bus_t    bus,
  input  logic [32:0] timestamp,
  output logic [7:0]  dout,
  output logic        onesecond_irq,
  output logic        qtrsecond_irq
);

  rtc_mem_req_t pram_req;
  rtc_mem_req_t clk_req;
  logic [7:0]   pram_rdata;
  logic [7:0]   clk_rdata;

  rtc_cmd_seq u_seq (
    .CLK_14M    (CLK_14M),
    .rst_n      (rst_n),
    .bus        (bus),
    .dout       (dout),
    .pram_req   (pram_req),
    .clk_req    (clk_req),
    .pram_rdata (pram_rdata),
    .clk_rdata  (clk_rdata)
  );

  rtc_pram u_pram (
    .CLK_14M (CLK_14M),
    .req     (pram_req),
    .rdata   (pram_rdata)
  );

  rtc_seconds #(
    .ticks_per_sec (ticks_per_sec)
  ) u_seconds (
    .CLK_14M       (CLK_14M),
    .rst_n         (rst_n),
    .timestamp     (timestamp),
    .req           (clk_req),
    .rdata         (clk_rdata),
    .onesecond_irq (onesecond_irq),
    .qtrsecond_irq (qtrsecond_irq)
  );

endmodule

//--- verification/rtc_props.sv
`timescale 1ns/1ns

module rtc_props (
  input logic CLK_14M,
  input logic rst_n,
  input logic onesecond_irq,
  input logic qtrsecond_irq,
  input logic pram_en,
  input logic clk_en
);

  int unsigned fail_cnt = 0;  // read by the testbench at the end

  a_sec_single: assert property (@(posedge CLK_14M) disable iff (!rst_n)
    onesecond_irq |=> !onesecond_irq)
    else begin
      $error("onesecond_irq high for two cycles in a row");
      fail_cnt++;
    end

  a_qtr_single: assert property (@(posedge CLK_14M) disable iff (!rst_n)
    qtrsecond_irq |=> !qtrsecond_irq)
    else begin
      $error("qtrsecond_irq high for two cycles in a row");
      fail_cnt++;
    end

  // every full second is also a quarter boundary
  a_sec_has_qtr: assert property (@(posedge CLK_14M) disable iff (!rst_n)
    onesecond_irq |-> qtrsecond_irq)
    else begin
      $error("onesecond_irq without qtrsecond_irq");
      fail_cnt++;
    end

  a_one_target: assert property (@(posedge CLK_14M) disable iff (!rst_n)
    !(pram_en && clk_en))
    else begin
      $error("parameter RAM and clock requests in the same cycle");
      fail_cnt++;
    end

  a_quiet_in_reset: assert property (@(posedge CLK_14M)
    !rst_n |-> (!onesecond_irq && !qtrsecond_irq))
    else begin
      $error("interrupt high during reset");
      fail_cnt++;
    end

endmodule

bind rtc_top rtc_props u_props (
  .CLK_14M       (CLK_14M),
  .rst_n         (rst_n),
  .onesecond_irq (onesecond_irq),
  .qtrsecond_irq (qtrsecond_irq),
  .pram_en       (pram_req.en),
  .clk_en        (clk_req.en)
);

//--- verification/rtc_tb.sv
`timescale 1ns/1ns

module rtc_tb import rtc_pkg::*; ();

  logic        CLK_14M;
  logic        rst_n;
  rtc_bus_t    bus;
  logic [32:0] timestamp;
  logic [7:0]  dout;
  logic        onesecond_irq;
  logic        qtrsecond_irq;

  int unsigned checks;
  int unsigned errors;
  int unsigned timeouts;
  int unsigned pulse_cnt = 0;  // onesecond_irq pulses since reset

  rtc_top #(
    .ticks_per_sec (400)
  ) UUT (
    .CLK_14M       (CLK_14M),
    .rst_n         (rst_n),
    .bus           (bus),
    .timestamp     (timestamp),
    .dout          (dout),
    .onesecond_irq (onesecond_irq),
    .qtrsecond_irq (qtrsecond_irq)
  );

  initial begin
    CLK_14M = 1'b0;
    forever #10 CLK_14M = ~CLK_14M;
  end

  always @(posedge CLK_14M) begin
    if (rst_n && onesecond_irq) pulse_cnt <= pulse_cnt + 1;
  end

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns %s got %02h expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic check_pulse(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    int unsigned bad;
    bad = errors + timeouts + UUT.u_props.fail_cnt;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, UUT.u_props.fail_cnt);
    if (bad == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // strobe for one cycle and then two idle cycles
  task automatic bus_write(input logic a, input logic [7:0] d);
    @(posedge CLK_14M);
    bus.addr   <= a;
    bus.rw     <= 1'b0;
    bus.din    <= d;
    bus.strobe <= 1'b1;
    bus.cen    <= 1'b1;
    @(posedge CLK_14M);
    bus.strobe <= 1'b0;
    bus.cen    <= 1'b0;
    repeat (2) @(posedge CLK_14M);
  endtask

  task automatic bus_read(input logic a, output logic [7:0] d);
    @(posedge CLK_14M);
    bus.addr   <= a;
    bus.rw     <= 1'b1;
    bus.strobe <= 1'b1;
    bus.cen    <= 1'b1;
    @(posedge CLK_14M);
    bus.strobe <= 1'b0;
    bus.cen    <= 1'b0;
    repeat (2) @(posedge CLK_14M);
    d = dout;  // held since the read
  endtask

  task automatic seq_step(input logic rd);
    bus_write(1'b1, rd ? 8'hC0 : 8'h80);
  endtask

  task automatic data_phase(input logic rd, input logic [7:0] wdata, output logic [7:0] rdata);
    rdata = 8'h00;
    if (!rd) bus_write(1'b0, wdata);
    seq_step(rd);
    if (rd) bus_read(1'b0, rdata);  // c033 reloaded two cycles after the step
  endtask

  task automatic clock_rw(input logic [1:0] idx, input logic rd, input logic [7:0] wdata,
                          output logic [7:0] rdata);
    bus_write(1'b0, {4'b0000, idx, 2'b01});
    seq_step(1'b0);
    data_phase(rd, wdata, rdata);
  endtask

  task automatic pram_rw(input logic [7:0] addr, input logic ext, input logic rd,
                         input logic [7:0] wdata, output logic [7:0] rdata);
    if (ext) begin
      bus_write(1'b0, {5'b00111, addr[7:5]});
      seq_step(1'b0);
      bus_write(1'b0, {1'b0, addr[4:0], 2'b00});  // low five bits
      seq_step(1'b0);
    end else if (addr < 8'h10) begin
      bus_write(1'b0, {2'b01, addr[3:0], 2'b01});
      seq_step(1'b0);
    end else begin
      bus_write(1'b0, {4'b0010, addr[1:0], 2'b01});  // 0x10 to 0x13
      seq_step(1'b0);
    end
    data_phase(rd, wdata, rdata);
  endtask

  // test and write protect commands have no visible effect
  task automatic internal_cmd(input logic sel);
    bus_write(1'b0, {5'b00110, sel, 2'b01});
    seq_step(1'b0);
    seq_step(1'b0);
  endtask

  task automatic wait_sec_pulse();
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < 1000 && !seen; n++) begin
      @(posedge CLK_14M);
      seen = onesecond_irq;
    end
    if (!seen) begin
      timeouts++;
      $display("timeout while waiting for a onesecond_irq pulse");
    end
  endtask

  task automatic reset_state();
    logic [7:0] b;
    bus_read(1'b0, b);
    check_byte("dout c033", b, 8'h00);
    bus_read(1'b1, b);
    check_byte("dout c034", b, 8'h00);
    check_pulse("onesecond_irq", onesecond_irq, 1'b0);
    check_pulse("qtrsecond_irq", qtrsecond_irq, 1'b0);
  endtask

  task automatic reg_readback();
    logic [7:0] b;
    bus_write(1'b0, 8'hA5);
    bus_read(1'b0, b);
    check_byte("dout c033", b, 8'hA5);
    bus_write(1'b1, 8'h6B);
    bus_read(1'b1, b);
    check_byte("dout c034", b, 8'h6B);
    bus_write(1'b0, 8'h00);  // no command so the step stays idle
    bus_write(1'b1, 8'hC5);
    bus_read(1'b1, b);
    check_byte("dout c034", b, 8'h45);
  endtask

  task automatic clock_epoch();
    logic [31:0] got;
    logic [31:0] exp;
    logic [7:0]  b;
    for (int i = 0; i < 4; i++) begin
      clock_rw(2'(i), 1'b1, 8'h00, b);
      got[8*i +: 8] = b;
    end
    exp = timestamp[31:0] + mac_epoch_offset + pulse_cnt;
    for (int i = 0; i < 4; i++) begin
      check_byte($sformatf("clock byte %0d", i), got[8*i +: 8], exp[8*i +: 8]);
    end
  endtask

  task automatic clock_write_back();
    logic [31:0] val;
    logic [31:0] got;
    logic [31:0] exp;
    logic [7:0]  b;
    int unsigned p0;
    val      = $urandom;
    val[7:0] = val[7:0] & 8'h7F;  // no carry out of the low byte
    val[31]  = 1'b1;
    wait_sec_pulse();  // a full second of room for the writes
    for (int i = 0; i < 4; i++) begin
      clock_rw(2'(i), 1'b0, val[8*i +: 8], b);
    end
    p0 = pulse_cnt;
    wait_sec_pulse();
    for (int i = 0; i < 4; i++) begin
      clock_rw(2'(i), 1'b1, 8'h00, b);
      got[8*i +: 8] = b;
    end
    exp = val + (pulse_cnt - p0);
    for (int i = 0; i < 4; i++) begin
      check_byte($sformatf("clock byte %0d", i), got[8*i +: 8], exp[8*i +: 8]);
    end
  endtask

  task automatic pram_defaults();
    logic [7:0] b;
    pram_rw(8'h03, 1'b0, 1'b1, 8'h00, b);
    check_byte("pram[03]", b, 8'h01);
    pram_rw(8'h0C, 1'b0, 1'b1, 8'h00, b);
    check_byte("pram[0c]", b, 8'h01);
    pram_rw(8'h12, 1'b0, 1'b1, 8'h00, b);
    check_byte("pram[12]", b, 8'h07);
    pram_rw(8'h5F, 1'b1, 1'b1, 8'h00, b);
    check_byte("pram[5f]", b, 8'h81);
    pram_rw(8'hFC, 1'b1, 1'b1, 8'h00, b);
    check_byte("pram[fc]", b, 8'h71);
  endtask

  task automatic pram_write_readback();
    logic [7:0] addrs [20];
    logic [7:0] model [256];
    logic [7:0] a;
    logic [7:0] d;
    logic [7:0] b;
    for (int i = 0; i < 20; i++) begin
      a = (i % 2 == 0) ? 8'($urandom_range(0, 19)) : 8'($urandom);  // even ones fit short form
      d = 8'($urandom);
      pram_rw(a, (i % 2 == 1) || (a >= 8'h14), 1'b0, d, b);
      addrs[i] = a;
      model[a] = d;
      if (i % 5 == 4) internal_cmd(i[1]);
    end
    for (int i = 0; i < 20; i++) begin
      pram_rw(addrs[i], 1'b1, 1'b1, 8'h00, b);
      check_byte($sformatf("pram[%02h]", addrs[i]), b, model[addrs[i]]);
    end
  endtask

  // one full second sampled every cycle
  task automatic irq_cadence();
    wait_sec_pulse();
    for (int k = 1; k <= 400; k++) begin
      @(posedge CLK_14M);
      check_pulse("onesecond_irq", onesecond_irq, k == 400);
      check_pulse("qtrsecond_irq", qtrsecond_irq, (k % 100) == 0);
    end
  endtask

  initial begin
    void'($urandom(86));
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    rst_n     = 1'b0;
    bus       = '0;
    timestamp = 33'h0_6553_F100;
    repeat (10) @(posedge CLK_14M);
    rst_n <= 1'b1;
    reset_state();
    reg_readback();
    clock_epoch();
    clock_write_back();
    pram_defaults();
    pram_write_readback();
    irq_cadence();
    finish_run();
  end

endmodule

//--- sim.f
+incdir+include
logic/rtc_pkg.sv
logic/rtc_pram.sv
logic/rtc_seconds.sv
logic/rtc_cmd_seq.sv
logic/rtc_top.sv
verification/rtc_props.sv
verification/rtc_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rtc_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
